/* ctrl_pkg.sv */
////////////////////
// ctrl_pkg
// register bus widths, register map offsets
// and error-merge constants for the DMA
// control block
////////////////////

package ctrl_pkg;

    localparam int REG_ADDR_WIDTH = 16;
    localparam int REG_DATA_WIDTH = 32;

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [REG_DATA_WIDTH-1:0] reg_data_t;

    localparam reg_addr_t REG_DMA_ENABLE = 16'h0000;

    // read descriptor staging
    localparam reg_addr_t REG_RD_PCIE_ADDR_LO = 16'h0100;
    localparam reg_addr_t REG_RD_PCIE_ADDR_HI = 16'h0104;
    localparam reg_addr_t REG_RD_AXI_ADDR     = 16'h0108;
    localparam reg_addr_t REG_RD_LEN          = 16'h0110;
    localparam reg_addr_t REG_RD_TAG          = 16'h0114;
    localparam reg_addr_t REG_RD_STATUS       = 16'h0118;

    // write descriptor staging
    localparam reg_addr_t REG_WR_PCIE_ADDR_LO = 16'h0200;
    localparam reg_addr_t REG_WR_PCIE_ADDR_HI = 16'h0204;
    localparam reg_addr_t REG_WR_AXI_ADDR     = 16'h0208;
    localparam reg_addr_t REG_WR_LEN          = 16'h0210;
    localparam reg_addr_t REG_WR_TAG          = 16'h0214;
    localparam reg_addr_t REG_WR_STATUS       = 16'h0218;

    // packet counters
    localparam reg_addr_t REG_RQ_COUNT = 16'h0400;
    localparam reg_addr_t REG_RC_COUNT = 16'h0404;
    localparam reg_addr_t REG_CQ_COUNT = 16'h0408;
    localparam reg_addr_t REG_CC_COUNT = 16'h040C;

    localparam int STATUS_VALID_BIT = 31;
    localparam int COUNT_WIDTH      = 32;

    localparam int ERR_SOURCES     = 3;
    localparam int ERR_COUNT_WIDTH = 4;

endpackage

/* dma_pkg.sv */
////////////////////
// dma_pkg
// descriptor field widths and types shared
// with the external DMA engine
////////////////////

package dma_pkg;

    localparam int PCIE_ADDR_WIDTH = 64;
    localparam int AXI_ADDR_WIDTH  = 32;
    localparam int LEN_WIDTH       = 16;
    localparam int TAG_WIDTH       = 8;

    typedef logic [PCIE_ADDR_WIDTH-1:0] pcie_addr_t;
    typedef logic [AXI_ADDR_WIDTH-1:0]  axi_addr_t;
    typedef logic [LEN_WIDTH-1:0]       dma_len_t;
    typedef logic [TAG_WIDTH-1:0]       dma_tag_t;

endpackage

/* reg_access_fsm.sv */
////////////////////
// reg_access_fsm
// request/response handshake for the register
// port, independent write and read channels
////////////////////

`timescale 1ns/1ps

module reg_access_fsm (
    input  logic clk,
    input  logic rst,

    input  logic wr_valid,
    output logic wr_ready,
    output logic wr_resp_valid,
    input  logic wr_resp_ready,

    input  logic rd_valid,
    output logic rd_ready,
    output logic rd_data_valid,
    input  logic rd_data_ready,

    output logic wr_en,
    output logic rd_en
);

    // each channel is idle or response-pending; the response valid is the state bit
    assign wr_en = wr_valid && !wr_resp_valid;
    assign rd_en = rd_valid && !rd_data_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ready      <= 1'b0;
            wr_resp_valid <= 1'b0;
            rd_ready      <= 1'b0;
            rd_data_valid <= 1'b0;
        end else begin
            wr_ready <= wr_en;
            rd_ready <= rd_en;

            if (wr_en) begin
                wr_resp_valid <= 1'b1;
            end else if (wr_resp_ready) begin
                wr_resp_valid <= 1'b0;
            end

            if (rd_en) begin
                rd_data_valid <= 1'b1;
            end else if (rd_data_ready) begin
                rd_data_valid <= 1'b0;
            end
        end
    end

    // host must see the response until it takes it
    wr_resp_held: assert property (@(posedge clk) disable iff (rst)
        wr_resp_valid && !wr_resp_ready |=> wr_resp_valid);

    rd_resp_held: assert property (@(posedge clk) disable iff (rst)
        rd_data_valid && !rd_data_ready |=> rd_data_valid);

endmodule

/* ctrl_regfile.sv */
////////////////////
// ctrl_regfile
// DMA enable, descriptor staging and issue,
// completion status readback, counter readback
// and the registered read data mux
////////////////////

`timescale 1ns/1ps

module ctrl_regfile
    import ctrl_pkg::*, dma_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       wr_en,
    input  logic       rd_en,
    input  reg_addr_t  wr_addr,
    input  reg_addr_t  rd_addr,
    input  reg_data_t  wr_data,
    output reg_data_t  rd_data,
    output logic       dma_enable,

    output pcie_addr_t rd_desc_pcie_addr,
    output axi_addr_t  rd_desc_axi_addr,
    output dma_len_t   rd_desc_len,
    output dma_tag_t   rd_desc_tag,
    output logic       rd_desc_valid,
    input  logic       rd_desc_ready,

    output pcie_addr_t wr_desc_pcie_addr,
    output axi_addr_t  wr_desc_axi_addr,
    output dma_len_t   wr_desc_len,
    output dma_tag_t   wr_desc_tag,
    output logic       wr_desc_valid,
    input  logic       wr_desc_ready,

    input  dma_tag_t   rd_status_tag,
    input  logic       rd_status_valid,
    output logic       rd_status_ready,
    input  dma_tag_t   wr_status_tag,
    input  logic       wr_status_valid,
    output logic       wr_status_ready,
    output logic       msi_irq,

    input  reg_data_t  rq_count,
    input  reg_data_t  rc_count,
    input  reg_data_t  cq_count,
    input  reg_data_t  cc_count
);

    reg_addr_t wr_addr_word;
    reg_addr_t rd_addr_word;
    reg_data_t rd_data_next;
    logic      rd_status_hit;
    logic      wr_status_hit;

    function automatic reg_data_t status_word(input dma_tag_t tag, input logic valid);
        reg_data_t word;
        word = '0;
        if (valid) begin
            word[TAG_WIDTH-1:0]    = tag;
            word[STATUS_VALID_BIT] = 1'b1;
        end
        return word;
    endfunction

    // word aligned decode
    assign wr_addr_word = {wr_addr[REG_ADDR_WIDTH-1:2], 2'b00};
    assign rd_addr_word = {rd_addr[REG_ADDR_WIDTH-1:2], 2'b00};

    assign msi_irq = rd_status_valid || wr_status_valid;

    // pop status only when the read actually saw it
    assign rd_status_hit = rd_en && (rd_addr_word == REG_RD_STATUS) && rd_status_valid;
    assign wr_status_hit = rd_en && (rd_addr_word == REG_WR_STATUS) && wr_status_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            dma_enable      <= 1'b0;
            rd_desc_valid   <= 1'b0;
            wr_desc_valid   <= 1'b0;
            rd_status_ready <= 1'b0;
            wr_status_ready <= 1'b0;
        end else begin
            if (rd_desc_ready) begin
                rd_desc_valid <= 1'b0;
            end
            if (wr_desc_ready) begin
                wr_desc_valid <= 1'b0;
            end
            // tag write issues the descriptor
            if (wr_en) begin
                case (wr_addr_word)
                    REG_DMA_ENABLE: dma_enable    <= wr_data[0];
                    REG_RD_TAG:     rd_desc_valid <= 1'b1;
                    REG_WR_TAG:     wr_desc_valid <= 1'b1;
                    default: ;
                endcase
            end
            rd_status_ready <= rd_status_hit;
            wr_status_ready <= wr_status_hit;
        end
    end

    // descriptor fields
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (wr_addr_word)
                REG_RD_PCIE_ADDR_LO: rd_desc_pcie_addr[REG_DATA_WIDTH-1:0] <= wr_data;
                REG_RD_PCIE_ADDR_HI: rd_desc_pcie_addr[PCIE_ADDR_WIDTH-1:REG_DATA_WIDTH] <= wr_data;
                REG_RD_AXI_ADDR:     rd_desc_axi_addr <= wr_data[AXI_ADDR_WIDTH-1:0];
                REG_RD_LEN:          rd_desc_len <= wr_data[LEN_WIDTH-1:0];
                REG_RD_TAG:          rd_desc_tag <= wr_data[TAG_WIDTH-1:0];
                REG_WR_PCIE_ADDR_LO: wr_desc_pcie_addr[REG_DATA_WIDTH-1:0] <= wr_data;
                REG_WR_PCIE_ADDR_HI: wr_desc_pcie_addr[PCIE_ADDR_WIDTH-1:REG_DATA_WIDTH] <= wr_data;
                REG_WR_AXI_ADDR:     wr_desc_axi_addr <= wr_data[AXI_ADDR_WIDTH-1:0];
                REG_WR_LEN:          wr_desc_len <= wr_data[LEN_WIDTH-1:0];
                REG_WR_TAG:          wr_desc_tag <= wr_data[TAG_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        rd_data_next = '0;
        case (rd_addr_word)
            REG_DMA_ENABLE: rd_data_next[0] = dma_enable;
            REG_RD_STATUS:  rd_data_next = status_word(rd_status_tag, rd_status_valid);
            REG_WR_STATUS:  rd_data_next = status_word(wr_status_tag, wr_status_valid);
            REG_RQ_COUNT:   rd_data_next = rq_count;
            REG_RC_COUNT:   rd_data_next = rc_count;
            REG_CQ_COUNT:   rd_data_next = cq_count;
            REG_CC_COUNT:   rd_data_next = cc_count;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= rd_data_next;
        end
    end

    // request stays up until the engine takes it
    rd_desc_held: assert property (@(posedge clk) disable iff (rst)
        rd_desc_valid && !rd_desc_ready |=> rd_desc_valid);

    wr_desc_held: assert property (@(posedge clk) disable iff (rst)
        wr_desc_valid && !wr_desc_ready |=> wr_desc_valid);

endmodule

/* tlp_counters.sv */
////////////////////
// tlp_counters
// completed-packet counts on the RQ, RC,
// CQ and CC streams
////////////////////

`timescale 1ns/1ps

module tlp_counters
    import ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      rq_valid,
    input  logic      rq_ready,
    input  logic      rq_last,
    input  logic      rc_valid,
    input  logic      rc_ready,
    input  logic      rc_last,
    input  logic      cq_valid,
    input  logic      cq_ready,
    input  logic      cq_last,
    input  logic      cc_valid,
    input  logic      cc_ready,
    input  logic      cc_last,

    output reg_data_t rq_count,
    output reg_data_t rc_count,
    output reg_data_t cq_count,
    output reg_data_t cc_count
);

    logic [3:0]             pkt_done;
    logic [COUNT_WIDTH-1:0] count [4];

    // last beat accepted ends a packet
    assign pkt_done[0] = rq_valid && rq_ready && rq_last;
    assign pkt_done[1] = rc_valid && rc_ready && rc_last;
    assign pkt_done[2] = cq_valid && cq_ready && cq_last;
    assign pkt_done[3] = cc_valid && cc_ready && cc_last;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (rst) begin
                count[i] <= '0;
            end else if (pkt_done[i]) begin
                count[i] <= count[i] + 1'b1;
            end
        end
    end

    assign rq_count = count[0];
    assign rc_count = count[1];
    assign cq_count = count[2];
    assign cc_count = count[3];

endmodule

/* error_pulse_merge.sv */
////////////////////
// error_pulse_merge
// serializes simultaneous error pulses into one
// pulse per cycle through a saturating backlog
////////////////////

`timescale 1ns/1ps

module error_pulse_merge
    import ctrl_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [ERR_SOURCES-1:0] pulse_in,
    output logic                   pulse_out
);

    logic [ERR_COUNT_WIDTH-1:0] count;
    logic [ERR_COUNT_WIDTH:0]   sum;

    // one extra bit to catch overflow before saturating
    always_comb begin
        sum = {1'b0, count};
        if (count != '0) begin
            sum = sum - 1'b1;
        end
        for (int i = 0; i < ERR_SOURCES; i++) begin
            sum = sum + pulse_in[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            pulse_out <= 1'b0;
        end else begin
            pulse_out <= (count != '0);
            if (sum[ERR_COUNT_WIDTH]) begin
                count <= '1;
            end else begin
                count <= sum[ERR_COUNT_WIDTH-1:0];
            end
        end
    end

    // a wrap would show as the backlog shrinking by more than one
    count_no_wrap: assert property (@(posedge clk) disable iff (rst)
        count != '0 |=> int'(count) >= int'($past(count)) - 1);

endmodule

/* pcie_ctrl_core.sv */
////////////////////
// pcie_ctrl_core
// control plane of the PCIe DMA: register port,
// descriptor issue, status and interrupt,
// packet counters and error pulse merging
////////////////////

`timescale 1ns/1ps

module pcie_ctrl_core
    import ctrl_pkg::*, dma_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   wr_valid,
    output logic                   wr_ready,
    input  reg_addr_t              wr_addr,
    input  reg_data_t              wr_data,
    output logic                   wr_resp_valid,
    input  logic                   wr_resp_ready,
    input  logic                   rd_valid,
    output logic                   rd_ready,
    input  reg_addr_t              rd_addr,
    output reg_data_t              rd_data,
    output logic                   rd_data_valid,
    input  logic                   rd_data_ready,

    output logic                   dma_enable,
    output pcie_addr_t             rd_desc_pcie_addr,
    output axi_addr_t              rd_desc_axi_addr,
    output dma_len_t               rd_desc_len,
    output dma_tag_t               rd_desc_tag,
    output logic                   rd_desc_valid,
    input  logic                   rd_desc_ready,
    output pcie_addr_t             wr_desc_pcie_addr,
    output axi_addr_t              wr_desc_axi_addr,
    output dma_len_t               wr_desc_len,
    output dma_tag_t               wr_desc_tag,
    output logic                   wr_desc_valid,
    input  logic                   wr_desc_ready,

    input  dma_tag_t               rd_status_tag,
    input  logic                   rd_status_valid,
    output logic                   rd_status_ready,
    input  dma_tag_t               wr_status_tag,
    input  logic                   wr_status_valid,
    output logic                   wr_status_ready,
    output logic                   msi_irq,

    input  logic                   rq_valid,
    input  logic                   rq_ready,
    input  logic                   rq_last,
    input  logic                   rc_valid,
    input  logic                   rc_ready,
    input  logic                   rc_last,
    input  logic                   cq_valid,
    input  logic                   cq_ready,
    input  logic                   cq_last,
    input  logic                   cc_valid,
    input  logic                   cc_ready,
    input  logic                   cc_last,

    input  logic [ERR_SOURCES-1:0] err_cor_in,
    input  logic [ERR_SOURCES-1:0] err_uncor_in,
    output logic                   err_cor,
    output logic                   err_uncor
);

    logic      wr_en;
    logic      rd_en;
    reg_data_t rq_count;
    reg_data_t rc_count;
    reg_data_t cq_count;
    reg_data_t cc_count;

    reg_access_fsm reg_access_fsm_inst (
        .clk           (clk),
        .rst           (rst),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .wr_resp_valid (wr_resp_valid),
        .wr_resp_ready (wr_resp_ready),
        .rd_valid      (rd_valid),
        .rd_ready      (rd_ready),
        .rd_data_valid (rd_data_valid),
        .rd_data_ready (rd_data_ready),
        .wr_en         (wr_en),
        .rd_en         (rd_en)
    );

    ctrl_regfile ctrl_regfile_inst (
        .clk               (clk),
        .rst               (rst),
        .wr_en             (wr_en),
        .rd_en             (rd_en),
        .wr_addr           (wr_addr),
        .rd_addr           (rd_addr),
        .wr_data           (wr_data),
        .rd_data           (rd_data),
        .dma_enable        (dma_enable),
        .rd_desc_pcie_addr (rd_desc_pcie_addr),
        .rd_desc_axi_addr  (rd_desc_axi_addr),
        .rd_desc_len       (rd_desc_len),
        .rd_desc_tag       (rd_desc_tag),
        .rd_desc_valid     (rd_desc_valid),
        .rd_desc_ready     (rd_desc_ready),
        .wr_desc_pcie_addr (wr_desc_pcie_addr),
        .wr_desc_axi_addr  (wr_desc_axi_addr),
        .wr_desc_len       (wr_desc_len),
        .wr_desc_tag       (wr_desc_tag),
        .wr_desc_valid     (wr_desc_valid),
        .wr_desc_ready     (wr_desc_ready),
        .rd_status_tag     (rd_status_tag),
        .rd_status_valid   (rd_status_valid),
        .rd_status_ready   (rd_status_ready),
        .wr_status_tag     (wr_status_tag),
        .wr_status_valid   (wr_status_valid),
        .wr_status_ready   (wr_status_ready),
        .msi_irq           (msi_irq),
        .rq_count          (rq_count),
        .rc_count          (rc_count),
        .cq_count          (cq_count),
        .cc_count          (cc_count)
    );

    tlp_counters tlp_counters_inst (
        .clk      (clk),
        .rst      (rst),
        .rq_valid (rq_valid),
        .rq_ready (rq_ready),
        .rq_last  (rq_last),
        .rc_valid (rc_valid),
        .rc_ready (rc_ready),
        .rc_last  (rc_last),
        .cq_valid (cq_valid),
        .cq_ready (cq_ready),
        .cq_last  (cq_last),
        .cc_valid (cc_valid),
        .cc_ready (cc_ready),
        .cc_last  (cc_last),
        .rq_count (rq_count),
        .rc_count (rc_count),
        .cq_count (cq_count),
        .cc_count (cc_count)
    );

    error_pulse_merge err_cor_merge_inst (
        .clk       (clk),
        .rst       (rst),
        .pulse_in  (err_cor_in),
        .pulse_out (err_cor)
    );

    error_pulse_merge err_uncor_merge_inst (
        .clk       (clk),
        .rst       (rst),
        .pulse_in  (err_uncor_in),
        .pulse_out (err_uncor)
    );

endmodule

/* tb_pcie_ctrl_core.sv */
////////////////////
// tb_pcie_ctrl_core
// directed testbench for the DMA control block:
// register port, descriptors, status and irq,
// packet counters and error merging
////////////////////

`timescale 1ns/1ps

module tb_pcie_ctrl_core
    import ctrl_pkg::*, dma_pkg::*;
;

    // whole run takes well under a thousand cycles
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int COUNT_BEATS    = 200;
    localparam int ERR_PATTERNS   = 8;
    localparam int PATTERN_CYCLES = 4;

    logic       clk;
    logic       rst;
    logic       wr_valid;
    logic       wr_ready;
    reg_addr_t  wr_addr;
    reg_data_t  wr_data;
    logic       wr_resp_valid;
    logic       wr_resp_ready;
    logic       rd_valid;
    logic       rd_ready;
    reg_addr_t  rd_addr;
    reg_data_t  rd_data;
    logic       rd_data_valid;
    logic       rd_data_ready;
    logic       dma_enable;
    pcie_addr_t rd_desc_pcie_addr;
    axi_addr_t  rd_desc_axi_addr;
    dma_len_t   rd_desc_len;
    dma_tag_t   rd_desc_tag;
    logic       rd_desc_valid;
    logic       rd_desc_ready;
    pcie_addr_t wr_desc_pcie_addr;
    axi_addr_t  wr_desc_axi_addr;
    dma_len_t   wr_desc_len;
    dma_tag_t   wr_desc_tag;
    logic       wr_desc_valid;
    logic       wr_desc_ready;
    dma_tag_t   rd_status_tag;
    logic       rd_status_valid;
    logic       rd_status_ready;
    dma_tag_t   wr_status_tag;
    logic       wr_status_valid;
    logic       wr_status_ready;
    logic       msi_irq;
    logic       rq_valid, rq_ready, rq_last;
    logic       rc_valid, rc_ready, rc_last;
    logic       cq_valid, cq_ready, cq_last;
    logic       cc_valid, cc_ready, cc_last;
    logic [ERR_SOURCES-1:0] err_cor_in;
    logic [ERR_SOURCES-1:0] err_uncor_in;
    logic       err_cor;
    logic       err_uncor;

    integer seed = 63;
    int     cycle_count = 0;
    int     status_pulses = 0;
    int     wr_status_pulses = 0;
    int     cor_pulses = 0;
    int     uncor_pulses = 0;

    pcie_ctrl_core pcie_ctrl_core_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("simulation timed out after %0d cycles without finishing", cycle_count);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    // output pulse monitors sampled mid-cycle
    always @(negedge clk) begin
        if (rd_status_ready) status_pulses++;
        if (wr_status_ready) wr_status_pulses++;
        if (err_cor) cor_pulses++;
        if (err_uncor) uncor_pulses++;
    end

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        wr_valid = 1'b1;
        wr_addr  = addr;
        wr_data  = data;
        do @(negedge clk); while (!wr_ready);
        assert (wr_resp_valid) else report_error("write response valid missing with wr_ready");
        wr_valid = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        rd_valid = 1'b1;
        rd_addr  = addr;
        do @(negedge clk); while (!rd_ready);
        assert (rd_data_valid) else report_error("read data valid missing with rd_ready");
        data     = rd_data;
        rd_valid = 1'b0;
    endtask

    function automatic int count_bits(input logic [ERR_SOURCES-1:0] bits);
        int n;
        n = 0;
        for (int i = 0; i < ERR_SOURCES; i++) begin
            n += bits[i];
        end
        return n;
    endfunction

    task automatic enable_and_unmapped();
        reg_data_t data;
        assert (dma_enable == 1'b0) else report_error("dma_enable set after reset");
        assert (!rd_desc_valid && !wr_desc_valid)
            else report_error("descriptor valid set after reset");
        reg_write(REG_DMA_ENABLE, 32'h1);
        assert (dma_enable == 1'b1) else report_error("dma_enable not set by write");
        reg_read(REG_DMA_ENABLE, data);
        assert (data == 32'h1)
            else report_error($sformatf("enable read 0x%08h, expected 0x1", data));
        reg_write(16'h0800, 32'hdead_beef);
        reg_read(16'h0800, data);
        assert (data == '0)
            else report_error($sformatf("unmapped read 0x%08h, expected 0", data));
    endtask

    task automatic read_desc_issue();
        reg_data_t lo, hi, axi, len, tag;
        lo  = $random(seed);
        hi  = $random(seed);
        axi = $random(seed);
        len = $random(seed);
        tag = $random(seed);
        reg_write(REG_RD_PCIE_ADDR_LO, lo);
        reg_write(REG_RD_PCIE_ADDR_HI, hi);
        reg_write(REG_RD_AXI_ADDR, axi);
        reg_write(REG_RD_LEN, len);
        assert (!rd_desc_valid) else report_error("read descriptor issued before tag write");
        reg_write(REG_RD_TAG, tag);
        assert (rd_desc_pcie_addr == {hi, lo})
            else report_error($sformatf("rd pcie addr 0x%016h", rd_desc_pcie_addr));
        assert (rd_desc_axi_addr == axi)
            else report_error($sformatf("rd axi addr 0x%08h", rd_desc_axi_addr));
        assert (rd_desc_len == len[LEN_WIDTH-1:0])
            else report_error($sformatf("rd len 0x%04h", rd_desc_len));
        assert (rd_desc_tag == tag[TAG_WIDTH-1:0])
            else report_error($sformatf("rd tag 0x%02h", rd_desc_tag));
        repeat (4) begin
            assert (rd_desc_valid) else report_error("rd_desc_valid dropped without ready");
            @(negedge clk);
        end
        rd_desc_ready = 1'b1;
        @(negedge clk);
        rd_desc_ready = 1'b0;
        assert (!rd_desc_valid) else report_error("rd_desc_valid not cleared by ready");
    endtask

    task automatic write_desc_issue();
        reg_data_t lo, hi, axi, len, tag;
        lo  = $random(seed);
        hi  = $random(seed);
        axi = $random(seed);
        len = $random(seed);
        tag = $random(seed);
        reg_write(REG_WR_PCIE_ADDR_LO, lo);
        reg_write(REG_WR_PCIE_ADDR_HI, hi);
        reg_write(REG_WR_AXI_ADDR, axi);
        reg_write(REG_WR_LEN, len);
        reg_write(REG_WR_TAG, tag);
        assert (wr_desc_pcie_addr == {hi, lo})
            else report_error($sformatf("wr pcie addr 0x%016h", wr_desc_pcie_addr));
        assert (wr_desc_axi_addr == axi)
            else report_error($sformatf("wr axi addr 0x%08h", wr_desc_axi_addr));
        assert (wr_desc_len == len[LEN_WIDTH-1:0])
            else report_error($sformatf("wr len 0x%04h", wr_desc_len));
        assert (wr_desc_tag == tag[TAG_WIDTH-1:0])
            else report_error($sformatf("wr tag 0x%02h", wr_desc_tag));
        // the read engine's ready must leave this descriptor alone
        repeat (3) begin
            rd_desc_ready = 1'b1;
            @(negedge clk);
            rd_desc_ready = 1'b0;
            assert (wr_desc_valid) else report_error("wr_desc_valid cleared by rd_desc_ready");
        end
        wr_desc_ready = 1'b1;
        @(negedge clk);
        wr_desc_ready = 1'b0;
        assert (!wr_desc_valid) else report_error("wr_desc_valid not cleared by ready");
    endtask

    task automatic status_and_irq();
        reg_data_t data;
        reg_data_t expected;
        int        pulses_before;
        dma_tag_t  tag;
        tag             = $random(seed);
        rd_status_tag   = tag;
        rd_status_valid = 1'b1;
        @(negedge clk);
        assert (msi_irq) else report_error("msi_irq low with read status pending");
        expected                   = '0;
        expected[STATUS_VALID_BIT] = 1'b1;
        expected[TAG_WIDTH-1:0]    = tag;
        pulses_before = status_pulses;
        reg_read(REG_RD_STATUS, data);
        assert (data == expected)
            else report_error($sformatf("status read 0x%08h, expected 0x%08h", data, expected));
        repeat (3) @(negedge clk);
        assert (status_pulses == pulses_before + 1)
            else report_error($sformatf("%0d rd_status_ready pulses, expected 1",
                status_pulses - pulses_before));
        // engine takes the pop and drops its status
        rd_status_valid = 1'b0;
        reg_read(REG_RD_STATUS, data);
        assert (data == '0)
            else report_error($sformatf("empty status read 0x%08h, expected 0", data));
        assert (!msi_irq) else report_error("msi_irq high with no status pending");

        // write status path
        tag             = $random(seed);
        wr_status_tag   = tag;
        wr_status_valid = 1'b1;
        @(negedge clk);
        assert (msi_irq) else report_error("msi_irq low with write status pending");
        expected                   = '0;
        expected[STATUS_VALID_BIT] = 1'b1;
        expected[TAG_WIDTH-1:0]    = tag;
        pulses_before = wr_status_pulses;
        reg_read(REG_WR_STATUS, data);
        assert (data == expected)
            else report_error($sformatf("wr status read 0x%08h, expected 0x%08h",
                data, expected));
        repeat (3) @(negedge clk);
        assert (wr_status_pulses == pulses_before + 1)
            else report_error($sformatf("%0d wr_status_ready pulses, expected 1",
                wr_status_pulses - pulses_before));
        wr_status_valid = 1'b0;
        reg_read(REG_WR_STATUS, data);
        assert (data == '0)
            else report_error($sformatf("empty wr status read 0x%08h, expected 0", data));
        assert (!msi_irq) else report_error("msi_irq high with no status pending");
    endtask

    task automatic packet_counting();
        logic [11:0] stim;
        reg_data_t   data;
        reg_data_t   expected [4];
        reg_addr_t   addr [4];
        addr = '{REG_RQ_COUNT, REG_RC_COUNT, REG_CQ_COUNT, REG_CC_COUNT};
        expected = '{0, 0, 0, 0};
        repeat (COUNT_BEATS) begin
            stim = $random(seed);
            {rq_valid, rq_ready, rq_last} = stim[2:0];
            {rc_valid, rc_ready, rc_last} = stim[5:3];
            {cq_valid, cq_ready, cq_last} = stim[8:6];
            {cc_valid, cc_ready, cc_last} = stim[11:9];
            for (int s = 0; s < 4; s++) begin
                if (stim[3*s +: 3] == 3'b111) expected[s]++;
            end
            @(negedge clk);
        end
        {rq_valid, rc_valid, cq_valid, cc_valid} = '0;
        @(negedge clk);
        for (int s = 0; s < 4; s++) begin
            reg_read(addr[s], data);
            assert (data == expected[s])
                else report_error($sformatf("counter 0x%04h read %0d, expected %0d",
                    addr[s], data, expected[s]));
        end
    endtask

    task automatic error_merging();
        logic [2*ERR_SOURCES-1:0] pat;
        int cor_expected;
        int uncor_expected;
        int quiet;
        for (int p = 0; p < ERR_PATTERNS; p++) begin
            cor_expected   = cor_pulses;
            uncor_expected = uncor_pulses;
            // at most 12 pulses per pattern keeps the backlog below saturation
            repeat (PATTERN_CYCLES) begin
                pat          = $random(seed);
                err_cor_in   = pat[ERR_SOURCES-1:0];
                err_uncor_in = pat[2*ERR_SOURCES-1:ERR_SOURCES];
                cor_expected   += count_bits(err_cor_in);
                uncor_expected += count_bits(err_uncor_in);
                @(negedge clk);
            end
            err_cor_in   = '0;
            err_uncor_in = '0;
            quiet = 0;
            while (quiet < 2) begin
                @(negedge clk);
                quiet = (err_cor || err_uncor) ? 0 : quiet + 1;
            end
            assert (cor_pulses == cor_expected)
                else report_error($sformatf("pattern %0d: %0d err_cor pulses, expected %0d",
                    p, cor_pulses, cor_expected));
            assert (uncor_pulses == uncor_expected)
                else report_error($sformatf("pattern %0d: %0d err_uncor pulses, expected %0d",
                    p, uncor_pulses, uncor_expected));
        end
    endtask

    initial begin
        rst             = 1'b1;
        wr_valid        = 1'b0;
        wr_addr         = '0;
        wr_data         = '0;
        wr_resp_ready   = 1'b1;
        rd_valid        = 1'b0;
        rd_addr         = '0;
        rd_data_ready   = 1'b1;
        rd_desc_ready   = 1'b0;
        wr_desc_ready   = 1'b0;
        rd_status_tag   = '0;
        rd_status_valid = 1'b0;
        wr_status_tag   = '0;
        wr_status_valid = 1'b0;
        {rq_valid, rq_ready, rq_last} = '0;
        {rc_valid, rc_ready, rc_last} = '0;
        {cq_valid, cq_ready, cq_last} = '0;
        {cc_valid, cc_ready, cc_last} = '0;
        err_cor_in      = '0;
        err_uncor_in    = '0;

        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        enable_and_unmapped();
        read_desc_issue();
        write_desc_issue();
        status_and_irq();
        packet_counting();
        error_merging();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* build.f */
ctrl_pkg.sv
dma_pkg.sv
reg_access_fsm.sv
ctrl_regfile.sv
tlp_counters.sv
error_pulse_merge.sv
pcie_ctrl_core.sv
tb_pcie_ctrl_core.sv

/* Bender.yml */
package:
  name: pcie_ctrl_core

sources:
  - ctrl_pkg.sv
  - dma_pkg.sv
  - reg_access_fsm.sv
  - ctrl_regfile.sv
  - tlp_counters.sv
  - error_pulse_merge.sv
  - pcie_ctrl_core.sv
  - target: test
    files:
      - tb_pcie_ctrl_core.sv
